/* sim.f */
+incdir+design
design/vertex_job_pkg.sv
design/vertex_read_sequencer.sv
design/vertex_line_unpacker.sv
design/vertex_job_fifo.sv
design/vertex_job_control.sv
bench/tb_memory_model.sv
bench/tb_vertex_job_control.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_vertex_job_control
FILELIST := sim.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the testbench prints its pass line
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_vertex_job_control.sv */
// array bases must be line aligned and at most 8 non-empty jobs are tracked per run
`timescale 1ns/100ps
`include "vertex_job_macros.svh"

module tb_vertex_job_control import vertex_job_pkg::*; ();

	localparam logic [7:0] OD_TAG = 8'h0d;
	localparam logic [7:0] EI_TAG = 8'h1e;
	localparam int MAX_JOBS = 8;
	localparam int ROOM_LIMIT = `VJ_JOB_DEPTH - `VJ_LINE_VERTICES;

	logic        clock;
	logic        rstn;
	job_desc_t   job;
	read_cmd_t   read_cmd;
	read_data_t  read_data;
	logic        vertex_request;
	vertex_job_t vertex;
	logic        vertex_valid;
	logic        busy;

	int cmd_errors = 0;
	int vertex_errors = 0;
	int ctrl_errors = 0;
	int timeouts = 0;

	// consumer modes
	logic drain = 1'b0;
	logic long_stalls = 1'b0;
	int   stall_left = 0;

	// reference state
	logic        job_accept = 1'b0;
	int          cmd_idx = 0;
	int          cur_n = 0;
	logic [31:0] cur_od = '0;
	logic [31:0] cur_ei = '0;
	int          job_count = 0;
	int          job_n [MAX_JOBS];
	logic [31:0] job_od [MAX_JOBS];
	logic [31:0] job_ei [MAX_JOBS];
	int          pop_job = 0;
	int          pop_vid = 0;
	int          issued = 0;
	int          popped = 0;

	array_sel_e         exp_sel;
	logic [31:0]        exp_addr;
	logic [15:0]        exp_count;
	int                 cmd_limit;
	vertex_job_t        exp_vertex;

	vertex_job_control i_vertex_job_control (
		.clock          (clock),
		.rstn           (rstn),
		.job            (job),
		.read_cmd       (read_cmd),
		.read_data      (read_data),
		.vertex_request (vertex_request),
		.vertex         (vertex),
		.vertex_valid   (vertex_valid),
		.busy           (busy)
	);

	tb_memory_model #(
		.OD_TAG (OD_TAG),
		.EI_TAG (EI_TAG)
	) i_tb_memory_model (
		.clock     (clock),
		.rstn      (rstn),
		.read_cmd  (read_cmd),
		.read_data (read_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] word_of(input logic [7:0] tag, input logic [31:0] base,
		input int v);
		return {tag, 24'((base >> 2) + v)};
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	always_comb begin
		int line_idx;
		int left;
		line_idx  = cmd_idx / 2;
		left      = cur_n - line_idx * `VJ_LINE_VERTICES;
		exp_sel   = (cmd_idx % 2 == 1) ? arr_edges_idx : arr_out_degree;
		exp_addr  = ((cmd_idx % 2 == 1) ? cur_ei : cur_od) + 32'(line_idx * `VJ_LINE_BYTES);
		exp_count = 16'((left > `VJ_LINE_VERTICES) ? `VJ_LINE_VERTICES : left);
		cmd_limit = 2 * ((cur_n + `VJ_LINE_VERTICES - 1) / `VJ_LINE_VERTICES);
		exp_vertex.id         = 16'(pop_vid);
		exp_vertex.out_degree = word_of(OD_TAG, job_od[pop_job % MAX_JOBS], pop_vid);
		exp_vertex.edges_idx  = word_of(EI_TAG, job_ei[pop_job % MAX_JOBS], pop_vid);
	end

	always @(posedge clock) begin
		if (!rstn) begin
			cmd_idx <= 0;
			cur_n   <= 0;
		end else if (job.valid && job_accept) begin
			// accepted job
			cur_n   <= int'(job.num_vertices);
			cur_od  <= job.out_degree_base;
			cur_ei  <= job.edges_idx_base;
			cmd_idx <= 0;
			if (job.num_vertices != 0) begin
				job_n[job_count]  <= int'(job.num_vertices);
				job_od[job_count] <= job.out_degree_base;
				job_ei[job_count] <= job.edges_idx_base;
				job_count         <= job_count + 1;
			end
		end else if (read_cmd.valid) begin
			cmd_idx <= cmd_idx + 1;
			if (read_cmd.array_sel == arr_out_degree)
				issued <= issued + int'(read_cmd.count);
		end

		if (rstn && vertex_request && vertex_valid) begin
			popped <= popped + 1;
			if (pop_vid + 1 == job_n[pop_job % MAX_JOBS]) begin
				pop_job <= pop_job + 1;
				pop_vid <= 0;
			end else begin
				pop_vid <= pop_vid + 1;
			end
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	cmd_fields: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd.valid |->
			{read_cmd.array_sel, read_cmd.address, read_cmd.count} == {exp_sel, exp_addr, exp_count})
		else begin
			cmd_errors++;
			$display("ERROR read_cmd {array_sel,address,count} got %h_%h_%h expected %h_%h_%h",
				$sampled(read_cmd.array_sel), $sampled(read_cmd.address), $sampled(read_cmd.count),
				$sampled(exp_sel), $sampled(exp_addr), $sampled(exp_count));
		end

	cmd_extra: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd.valid |-> cmd_idx < cmd_limit)
		else begin
			cmd_errors++;
			$display("read command issued beyond the last line of the job");
		end

	// a chunk may only start when a whole line fits in the queue
	cmd_room: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd.valid && read_cmd.array_sel == arr_out_degree |-> issued - popped <= ROOM_LIMIT)
		else begin
			cmd_errors++;
			$display("chunk issued while the job queue had no room for a line");
		end

	vertex_extra: assert property (@(posedge clock) disable iff (!rstn)
		vertex_request && vertex_valid |-> pop_job < job_count)
		else begin
			vertex_errors++;
			$display("vertex popped after every job was complete");
		end

	vertex_fields: assert property (@(posedge clock) disable iff (!rstn)
		vertex_request && vertex_valid |-> vertex == exp_vertex)
		else begin
			vertex_errors++;
			$display("ERROR vertex got %h expected %h", $sampled(vertex), $sampled(exp_vertex));
		end

	////////////////////////////////////////
	// consumer
	////////////////////////////////////////

	always @(negedge clock) begin
		if (drain) begin
			vertex_request = 1'b1;
		end else if (stall_left > 0) begin
			stall_left--;
			vertex_request = 1'b0;
		end else begin
			vertex_request = 1'($urandom_range(1, 0));
			if (long_stalls && $urandom_range(31, 0) == 0)
				stall_left = 60 + int'($urandom_range(99, 0));
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic finish_run();
		$display("command errors %0d, vertex errors %0d, control errors %0d, timeouts %0d",
			cmd_errors, vertex_errors, ctrl_errors, timeouts);
		if (cmd_errors + vertex_errors + ctrl_errors + timeouts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	endtask

	task automatic check_idle_outputs();
		assert ({read_cmd.valid, vertex_valid, busy} == 3'b000) else begin
			ctrl_errors++;
			$display("ERROR {read_cmd.valid,vertex_valid,busy} got %h expected 0",
				{read_cmd.valid, vertex_valid, busy});
		end
	endtask

	task automatic check_busy(input logic expected);
		assert (busy == expected) else begin
			ctrl_errors++;
			$display("ERROR busy got %h expected %h", busy, expected);
		end
	endtask

	// one-cycle job strobe between two falling edges
	task automatic send_job(input int n, input logic [31:0] od_base, input logic [31:0] ei_base,
		input logic accept);
		check_busy(!accept);
		job.valid           = 1'b1;
		job.num_vertices    = 16'(n);
		job.out_degree_base = od_base;
		job.edges_idx_base  = ei_base;
		job_accept          = accept;
		@(negedge clock);
		job        = '0;
		job_accept = 1'b0;
	endtask

	task automatic wait_not_busy(input int limit);
		int n;
		n = 0;
		while (busy && n < limit) begin
			@(negedge clock);
			n++;
		end
		if (busy) begin
			timeouts++;
			$display("busy stayed high for %0d cycles", limit);
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while ((pop_job != job_count || vertex_valid) && n < limit) begin
			@(negedge clock);
			n++;
		end
		if (pop_job != job_count || vertex_valid) begin
			timeouts++;
			$display("job queue did not drain within %0d cycles", limit);
		end
	endtask

	initial begin
		void'($urandom(32'hf321));
		rstn           = 1'b0;
		job            = '0;
		vertex_request = 1'b0;
		repeat (16) @(negedge clock);
		check_idle_outputs();
		rstn = 1'b1;
		@(negedge clock);
		check_idle_outputs();

		// two full lines and a short one plus an ignored strobe
		send_job(40, 32'h0000_1000, 32'h0000_8000, 1'b1);
		repeat (3) @(negedge clock);
		send_job(5, 32'h0000_3000, 32'h0000_5000, 1'b0);
		wait_not_busy(2000);

		// empty job drops busy two cycles after the strobe
		send_job(0, 32'h0000_9000, 32'h0000_a000, 1'b1);
		check_busy(1'b1);
		@(negedge clock);
		check_busy(1'b0);

		send_job(16, 32'h0001_0000, 32'h0001_4000, 1'b1);
		wait_not_busy(2000);

		// long stalls fill the queue and hold back chunks
		long_stalls = 1'b1;
		send_job(200, 32'h0002_0000, 32'h0004_0000, 1'b1);
		wait_not_busy(60000);
		send_job(1, 32'h0006_0040, 32'h0007_0fc0, 1'b1);
		wait_not_busy(60000);

		long_stalls = 1'b0;
		drain       = 1'b1;
		wait_drained(5000);
		assert (popped == 257) else begin
			ctrl_errors++;
			$display("ERROR popped got %h expected %h", popped, 257);
		end
		assert (job_count == 4) else begin
			ctrl_errors++;
			$display("ERROR job_count got %h expected %h", job_count, 4);
		end
		finish_run();
	end

endmodule

/* bench/tb_memory_model.sv */
// answers every command once after 1 to 8 cycles, at most one line per cycle; word = tag byte + address/4 + k
`timescale 1ns/100ps
`include "vertex_job_macros.svh"

module tb_memory_model import vertex_job_pkg::*; #(
	parameter logic [7:0] OD_TAG = 8'h0d,
	parameter logic [7:0] EI_TAG = 8'h1e
) (
	input  logic       clock,
	input  logic       rstn,
	input  read_cmd_t  read_cmd,
	output read_data_t read_data
);

	read_cmd_t pending[$];
	int        due[$];
	int        cycle = 0;

	// tag in the top byte, vertex index below
	function automatic logic [`VJ_LINE_W-1:0] build_line(input read_cmd_t cmd);
		logic [`VJ_LINE_W-1:0] line;
		logic [7:0]            tag;
		tag = (cmd.array_sel == arr_edges_idx) ? EI_TAG : OD_TAG;
		for (int k = 0; k < `VJ_LINE_VERTICES; k++)
			line[k*`VJ_VERTEX_W +: `VJ_VERTEX_W] = {tag, 24'((cmd.address >> 2) + k)};
		return line;
	endfunction

	initial read_data = '0;

	// capture commands with their due cycle
	always @(posedge clock) begin
		if (!rstn) begin
			pending.delete();
			due.delete();
		end else if (read_cmd.valid) begin
			pending.push_back(read_cmd);
			due.push_back(cycle + int'($urandom_range(8, 1)));
		end
		cycle++;
	end

	// first queued entry that is due goes out, so the two arrays may swap
	always @(negedge clock) begin : respond
		int         pick;
		read_data_t rsp;
		pick = -1;
		rsp  = '0;
		for (int i = 0; i < due.size(); i++)
			if (pick < 0 && due[i] <= cycle)
				pick = i;
		if (pick >= 0) begin
			rsp.valid     = 1'b1;
			rsp.array_sel = pending[pick].array_sel;
			rsp.count     = pending[pick].count;
			rsp.line      = build_line(pending[pick]);
			pending.delete(pick);
			due.delete(pick);
		end
		read_data = rsp;
	end

endmodule

/* design/vertex_job_control.sv */
// one job at a time; read_cmd has no back-pressure and read_data must answer every command once
`timescale 1ns/100ps
`include "vertex_job_macros.svh"

module vertex_job_control import vertex_job_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  job_desc_t   job,
	output read_cmd_t   read_cmd,
	input  read_data_t  read_data,
	input  logic        vertex_request,
	output vertex_job_t vertex,
	output logic        vertex_valid,
	output logic        busy
);

	logic        job_start;
	logic        line_done;
	logic        room;
	vertex_job_t push;
	logic        push_valid;

	////////////////////////////////////////
	// input side
	////////////////////////////////////////

	vertex_read_sequencer i_vertex_read_sequencer (
		.clock     (clock),
		.rstn      (rstn),
		.job       (job),
		.room      (room),
		.line_done (line_done),
		.read_cmd  (read_cmd),
		.job_start (job_start),
		.busy      (busy)
	);

	// line to vertex jobs
	vertex_line_unpacker i_vertex_line_unpacker (
		.clock      (clock),
		.rstn       (rstn),
		.job_start  (job_start),
		.read_data  (read_data),
		.push       (push),
		.push_valid (push_valid),
		.line_done  (line_done)
	);

	////////////////////////////////////////
	// output side
	////////////////////////////////////////

	vertex_job_fifo #(
		.DEPTH (`VJ_JOB_DEPTH)
	) i_vertex_job_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (push),
		.push_valid (push_valid),
		.pop        (vertex_request),
		.head       (vertex),
		.head_valid (vertex_valid),
		.room       (room)
	);

endmodule

/* design/vertex_job_fifo.sv */
// show-ahead queue; pops while empty are ignored and the writer must respect room
`timescale 1ns/100ps
`include "vertex_job_macros.svh"

module vertex_job_fifo import vertex_job_pkg::*; #(
	parameter int DEPTH = `VJ_JOB_DEPTH
) (
	input  logic        clock,
	input  logic        rstn,
	input  vertex_job_t push,
	input  logic        push_valid,
	input  logic        pop,
	output vertex_job_t head,
	output logic        head_valid,
	output logic        room
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);
	localparam logic [CNT_W-1:0] LINE_CNT = CNT_W'(`VJ_LINE_VERTICES);

	vertex_job_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	assign do_pop = pop && head_valid;

	// storage
	always_ff @(posedge clock) begin
		if (push_valid)
			mem[wr_ptr] <= push;
	end

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_valid)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;

			if (push_valid && !do_pop)
				count <= count + 1'b1;
			else if (!push_valid && do_pop)
				count <= count - 1'b1;
		end
	end

	// head straight from storage
	assign head       = mem[rd_ptr];
	assign head_valid = (count != '0);
	// a whole line of jobs still fits
	assign room       = (FULL_CNT - count) >= LINE_CNT;

	// room gating upstream keeps the queue from overflowing
	assert property (@(posedge clock) disable iff (!rstn)
		push_valid |-> count != FULL_CNT);

endmodule

/* design/vertex_line_unpacker.sv */
// both lines of a chunk must carry the same count; a new chunk may only arrive after line_done
`timescale 1ns/100ps
`include "vertex_job_macros.svh"

module vertex_line_unpacker import vertex_job_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        job_start,
	input  read_data_t  read_data,
	output vertex_job_t push,
	output logic        push_valid,
	output logic        line_done
);

	// line registers, one per array
	logic [`VJ_LINE_W-1:0] od_line;
	logic [`VJ_LINE_W-1:0] ei_line;

	// arrival flags
	logic od_ready;
	logic ei_ready;

	logic [`VJ_COUNT_W-1:0] left;
	logic [`VJ_COUNT_W-1:0] vertex_id;
	logic                   active;

	// both halves of the chunk present
	assign active = od_ready && ei_ready;

	////////////////////////////////////////
	// line capture and shift
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (read_data.valid && read_data.array_sel == arr_out_degree)
			od_line <= read_data.line;
		else if (active)
			od_line <= od_line >> `VJ_VERTEX_W;

		if (read_data.valid && read_data.array_sel == arr_edges_idx)
			ei_line <= read_data.line;
		else if (active)
			ei_line <= ei_line >> `VJ_VERTEX_W;
	end

	////////////////////////////////////////
	// flags and counters
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			od_ready <= 1'b0;
			ei_ready <= 1'b0;
			left     <= '0;
		end else begin
			// last word of the line clears both flags
			if (line_done) begin
				od_ready <= 1'b0;
				ei_ready <= 1'b0;
			end

			if (read_data.valid) begin
				left <= read_data.count;
				if (read_data.array_sel == arr_out_degree)
					od_ready <= 1'b1;
				else
					ei_ready <= 1'b1;
			end else if (active) begin
				left <= left - 1'b1;
			end
		end
	end

	// running id across the lines of a job
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_id <= '0;
		end else if (job_start) begin
			vertex_id <= '0;
		end else if (active) begin
			vertex_id <= vertex_id + 1'b1;
		end
	end

	////////////////////////////////////////
	// outputs
	////////////////////////////////////////

	always_comb begin
		push.id         = vertex_id;
		push.out_degree = od_line[`VJ_VERTEX_W-1:0];
		push.edges_idx  = ei_line[`VJ_VERTEX_W-1:0];
	end

	assign push_valid = active;
	assign line_done  = active && (left == 1);

	// a second line for the same array before the chunk drains means a sequencer fault
	assert property (@(posedge clock) disable iff (!rstn)
		read_data.valid |->
			(read_data.array_sel == arr_out_degree) ? !od_ready : !ei_ready);

endmodule

/* design/vertex_read_sequencer.sv */
// memory side must accept every command; jobs arriving while busy are dropped, not queued
`timescale 1ns/100ps
`include "vertex_job_macros.svh"

module vertex_read_sequencer import vertex_job_pkg::*; (
	input  logic      clock,
	input  logic      rstn,
	input  job_desc_t job,
	input  logic      room,
	input  logic      line_done,
	output read_cmd_t read_cmd,
	output logic      job_start,
	output logic      busy
);

	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_wait_room,
		st_send_od,
		st_send_ei,
		st_wait_line
	} state_t;

	localparam logic [`VJ_COUNT_W-1:0] LINE_VERTS = `VJ_LINE_VERTICES;
	localparam logic [`VJ_ADDR_W-1:0] LINE_BYTES = `VJ_LINE_BYTES;

	state_t state;
	state_t next_state;

	// latched job
	logic [`VJ_ADDR_W-1:0]  od_base;
	logic [`VJ_ADDR_W-1:0]  ei_base;
	logic [`VJ_COUNT_W-1:0] remaining;
	logic [`VJ_ADDR_W-1:0]  offset;
	logic [`VJ_COUNT_W-1:0] chunk_count;

	// short last line
	assign chunk_count = (remaining > LINE_VERTS) ? LINE_VERTS : remaining;

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (job.valid)
					next_state = st_start;
			end
			st_start: begin
				// empty job ends here
				if (remaining == '0)
					next_state = st_idle;
				else if (room)
					next_state = st_send_od;
				else
					next_state = st_wait_room;
			end
			st_wait_room: begin
				if (room)
					next_state = st_send_od;
			end
			st_send_od: begin
				next_state = st_send_ei;
			end
			st_send_ei: begin
				next_state = st_wait_line;
			end
			st_wait_line: begin
				// recheck room once the last push is counted
				if (line_done)
					next_state = (remaining == '0) ? st_idle : st_wait_room;
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////
	// job tracking
	////////////////////////////////////////

	// array bases latched on accept
	always_ff @(posedge clock) begin
		if (state == st_idle && job.valid) begin
			od_base <= job.out_degree_base;
			ei_base <= job.edges_idx_base;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
			offset    <= '0;
		end else if (state == st_idle && job.valid) begin
			remaining <= job.num_vertices;
			offset    <= '0;
		end else if (state == st_send_ei) begin
			// advance after the second command of the chunk
			remaining <= remaining - chunk_count;
			offset    <= offset + LINE_BYTES;
		end
	end

	////////////////////////////////////////
	// outputs
	////////////////////////////////////////

	always_comb begin
		read_cmd.valid     = (state == st_send_od) || (state == st_send_ei);
		read_cmd.array_sel = (state == st_send_ei) ? arr_edges_idx : arr_out_degree;
		read_cmd.address   = ((state == st_send_ei) ? ei_base : od_base) + offset;
		read_cmd.count     = chunk_count;
	end

	assign job_start = (state == st_start);
	assign busy      = (state != st_idle);

	// unpacker finishes a line only while one is outstanding
	assert property (@(posedge clock) disable iff (!rstn)
		line_done |-> state == st_wait_line);

endmodule

/* design/vertex_job_pkg.sv */
// command, data and job structs lead with a valid bit; line word 0 sits in the least significant bits
`include "vertex_job_macros.svh"

package vertex_job_pkg;

	////////////////////////////////////////
	// array selector
	////////////////////////////////////////

	// tags commands and returned lines
	typedef enum logic {
		arr_out_degree = 1'b0,
		arr_edges_idx  = 1'b1
	} array_sel_e;

	////////////////////////////////////////
	// bus payloads
	////////////////////////////////////////

	// job descriptor sent as a one-cycle strobe
	typedef struct packed {
		logic                     valid;
		logic [`VJ_COUNT_W-1:0]   num_vertices;
		logic [`VJ_ADDR_W-1:0]    out_degree_base;
		logic [`VJ_ADDR_W-1:0]    edges_idx_base;
	} job_desc_t;

	// one line read command
	typedef struct packed {
		logic                     valid;
		array_sel_e               array_sel;
		logic [`VJ_ADDR_W-1:0]    address;
		logic [`VJ_COUNT_W-1:0]   count;
	} read_cmd_t;

	// one returned line echoing the command tag and count
	typedef struct packed {
		logic                     valid;
		array_sel_e               array_sel;
		logic [`VJ_COUNT_W-1:0]   count;
		logic [`VJ_LINE_W-1:0]    line;
	} read_data_t;

	// one unpacked vertex
	typedef struct packed {
		logic [`VJ_COUNT_W-1:0]   id;
		logic [`VJ_VERTEX_W-1:0]  out_degree;
		logic [`VJ_VERTEX_W-1:0]  edges_idx;
	} vertex_job_t;

endpackage

/* design/vertex_job_macros.svh */
// widths and geometry shared by every block; the line size must equal vertices per line times the word size
`ifndef VERTEX_JOB_MACROS_SVH
`define VERTEX_JOB_MACROS_SVH

////////////////////////////////////////
// address and word widths
////////////////////////////////////////

`define VJ_ADDR_W 32
`define VJ_VERTEX_W 32

// vertex counts and vertex ids
`define VJ_COUNT_W 16

////////////////////////////////////////
// cache line geometry
////////////////////////////////////////

`define VJ_LINE_BYTES 64
`define VJ_LINE_VERTICES 16
`define VJ_LINE_W 512

////////////////////////////////////////
// job queue
////////////////////////////////////////

// must hold at least one full line of jobs
`define VJ_JOB_DEPTH 32

`endif
